/* src/m72_mem_defines.svh */
// Bus widths, CPU address map, SDRAM region bases and CPU clock enable divide
`ifndef M72_MEM_DEFINES_SVH
`define M72_MEM_DEFINES_SVH

// ======================================================================
// Widths
// ======================================================================
`define M72_CPU_AW    20
`define M72_SDR_AW    25
`define M72_HS_AW     17

// ======================================================================
// CPU address map
// ======================================================================
`define M72_ROM_END   20'h7FFFF     // ROM is read-only
`define M72_RAM_START 20'hA0000
`define M72_RAM_END   20'hA3FFF     // Work RAM window

// High-score accesses share the CPU RAM region base
`define M72_ROM_BASE  25'h0000000
`define M72_RAM_BASE  25'h0100000

// One CPU clock enable pulse per this many running cycles
`define M72_CE_DIV    4

`endif

/* src/cpu_bus_pkg.sv */
// CPU bus and high-score bus types for the SDRAM bridge
`default_nettype none
`include "m72_mem_defines.svh"

package cpu_bus_pkg;

    typedef logic [`M72_CPU_AW-1:0] cpu_addr_t;   // CPU byte address
    typedef logic [15:0]            data_word_t;
    typedef logic [1:0]             byte_sel_t;   // Bit 1 is the high lane
    typedef logic [`M72_HS_AW-1:0]  hs_addr_t;    // High-score byte address

    typedef struct packed {
        cpu_addr_t  addr;
        data_word_t dout;
        byte_sel_t  sel;
        logic       rd;
        logic       wr;
    } cpu_bus_t;

    typedef struct packed {
        hs_addr_t   addr;
        logic [7:0] din;
        logic       rd;
        logic       wr;
    } hs_bus_t;

endpackage

`default_nettype wire

/* src/sdram_pkg.sv */
// SDRAM request and response types for the CPU port
`default_nettype none
`include "m72_mem_defines.svh"

package sdram_pkg;

    typedef logic [`M72_SDR_AW-1:0] sdr_addr_t;

    // One access as sent to the SDRAM port
    typedef struct packed {
        sdr_addr_t               addr;
        cpu_bus_pkg::data_word_t din;
        cpu_bus_pkg::byte_sel_t  wr_sel;   // 00 means read
        logic                    is_hs;
        logic                    odd;
    } mem_req_t;

    // Returned word with the tag of the request that produced it
    typedef struct packed {
        cpu_bus_pkg::data_word_t data;
        logic                    is_hs;
        logic                    odd;
    } mem_resp_t;

endpackage

`default_nettype wire

/* src/request_capture.sv */
// Strobe edge detection, CPU region decode, byte realignment and request forming
`default_nettype none
`include "m72_mem_defines.svh"

module request_capture (
    input  wire                     CLK_32M,
    input  wire                     reset_n,
    input  wire cpu_bus_pkg::cpu_bus_t cpu_bus,
    input  wire cpu_bus_pkg::hs_bus_t  hs_bus,
    output sdram_pkg::mem_req_t     req,
    output logic                    req_valid
);

    logic cpu_rd_q;
    logic cpu_wr_q;
    logic hs_rd_q;
    logic hs_wr_q;
    logic cpu_edge;
    logic hs_edge;
    logic rom_hit;
    logic ram_hit;
    logic cpu_go;
    logic hs_go;
    cpu_bus_pkg::data_word_t cpu_word_out;
    cpu_bus_pkg::byte_sel_t  cpu_word_sel;
    sdram_pkg::sdr_addr_t    cpu_base;
    sdram_pkg::sdr_addr_t    cpu_word_addr;
    sdram_pkg::mem_req_t     req_nxt;

    // ==================================================================
    // Strobe edges
    // ==================================================================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            cpu_rd_q <= 1'b0;
            cpu_wr_q <= 1'b0;
            hs_rd_q  <= 1'b0;
            hs_wr_q  <= 1'b0;
        end else begin
            cpu_rd_q <= cpu_bus.rd;
            cpu_wr_q <= cpu_bus.wr;
            hs_rd_q  <= hs_bus.rd;
            hs_wr_q  <= hs_bus.wr;
        end
    end

    assign cpu_edge = (cpu_bus.rd & ~cpu_rd_q) | (cpu_bus.wr & ~cpu_wr_q);
    assign hs_edge  = (hs_bus.rd & ~hs_rd_q) | (hs_bus.wr & ~hs_wr_q);

    // ==================================================================
    // CPU decode and realignment
    // ==================================================================
    assign rom_hit = (cpu_bus.addr <= `M72_ROM_END);
    assign ram_hit = (cpu_bus.addr >= `M72_RAM_START) && (cpu_bus.addr <= `M72_RAM_END);

    assign cpu_base      = ram_hit ? `M72_RAM_BASE : `M72_ROM_BASE;
    assign cpu_word_addr = cpu_base |
        {{(`M72_SDR_AW-`M72_CPU_AW){1'b0}}, cpu_bus.addr[`M72_CPU_AW-1:1], 1'b0};

    // Odd byte goes out on the high lane
    assign cpu_word_out = cpu_bus.addr[0] ? {cpu_bus.dout[7:0], 8'h00} : cpu_bus.dout;
    assign cpu_word_sel = cpu_bus.addr[0] ? {cpu_bus.sel[0], 1'b0} : cpu_bus.sel;

    assign cpu_go = cpu_edge & (rom_hit | ram_hit);   // Unmapped makes no request
    assign hs_go  = hs_edge & ~cpu_go;                // CPU first

    always_comb begin
        req_nxt = '0;
        if (cpu_go) begin
            req_nxt.addr   = cpu_word_addr;
            req_nxt.din    = cpu_word_out;
            req_nxt.wr_sel = (cpu_bus.wr && ram_hit) ? cpu_word_sel : 2'b00;
            req_nxt.is_hs  = 1'b0;
            req_nxt.odd    = cpu_bus.addr[0];
        end else begin
            req_nxt.addr   = `M72_RAM_BASE | {{(`M72_SDR_AW-`M72_HS_AW){1'b0}}, hs_bus.addr};
            req_nxt.din    = {hs_bus.din, hs_bus.din};
            req_nxt.wr_sel = hs_bus.wr ? {hs_bus.addr[0], ~hs_bus.addr[0]} : 2'b00;
            req_nxt.is_hs  = 1'b1;
            req_nxt.odd    = hs_bus.addr[0];
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (cpu_go || hs_go) begin
            req <= req_nxt;
        end
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= cpu_go | hs_go;
        end
    end

    a_cpu_rd_wr_excl: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        !(cpu_bus.rd && cpu_bus.wr));

endmodule

`default_nettype wire

/* src/request_slot.sv */
// Single outstanding SDRAM request, SDRAM port drive and stalling CPU clock enable
`default_nettype none
`include "m72_mem_defines.svh"

module request_slot (
    input  wire                          CLK_32M,
    input  wire                          reset_n,
    input  wire sdram_pkg::mem_req_t     req,
    input  wire                          req_valid,
    input  wire cpu_bus_pkg::data_word_t sdr_dout,
    input  wire                          sdr_rdy,
    output sdram_pkg::sdr_addr_t         sdr_addr,
    output cpu_bus_pkg::data_word_t      sdr_din,
    output cpu_bus_pkg::byte_sel_t       sdr_wr_sel,
    output logic                         sdr_req,
    output logic                         sdr_busy,
    output sdram_pkg::mem_resp_t         resp,
    output logic                         resp_valid,
    output logic                         cpu_ce
);

    localparam int CE_W = $clog2(`M72_CE_DIV);
    localparam logic [CE_W-1:0] CE_LAST = CE_W'(`M72_CE_DIV - 1);

    typedef enum logic {
        IDLE,
        WAIT
    } slot_state_t;

    slot_state_t     state;
    slot_state_t     state_nxt;
    logic            accept;
    logic            done;
    logic            tag_is_hs;
    logic            tag_odd;
    logic [CE_W-1:0] ce_cnt;

    assign accept   = (state == IDLE) && req_valid;   // Busy slot drops the request
    assign done     = (state == WAIT) && sdr_rdy;
    assign sdr_busy = (state == WAIT);

    // ==================================================================
    // Slot FSM
    // ==================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) state_nxt = WAIT;
            end
            WAIT: begin
                if (sdr_rdy) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            state      <= IDLE;
            sdr_req    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            state      <= state_nxt;
            sdr_req    <= accept;
            resp_valid <= done;
        end
    end

    // SDRAM outputs hold until sdr_rdy
    always_ff @(posedge CLK_32M) begin
        if (accept) begin
            sdr_addr   <= req.addr;
            sdr_din    <= req.din;
            sdr_wr_sel <= req.wr_sel;
            tag_is_hs  <= req.is_hs;
            tag_odd    <= req.odd;
        end
        if (done) begin
            resp.data  <= sdr_dout;
            resp.is_hs <= tag_is_hs;
            resp.odd   <= tag_odd;
        end
    end

    // ==================================================================
    // CPU clock enable
    // ==================================================================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            ce_cnt <= '0;
            cpu_ce <= 1'b0;
        end else begin
            cpu_ce <= 1'b0;
            if (state_nxt == IDLE) begin   // Frozen while a request is outstanding
                ce_cnt <= (ce_cnt == CE_LAST) ? '0 : ce_cnt + 1'b1;
                cpu_ce <= (ce_cnt == CE_LAST);
            end
        end
    end

    a_rdy_only_in_wait: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        sdr_rdy |-> state == WAIT);

    a_req_one_cycle: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        sdr_req |=> !sdr_req);

endmodule

`default_nettype wire

/* src/response_steer.sv */
// Read data latch and steering to the CPU word or the high-score byte
`default_nettype none

module response_steer (
    input  wire                           CLK_32M,
    input  wire                           reset_n,
    input  wire sdram_pkg::mem_resp_t     resp,
    input  wire                           resp_valid,
    input  wire cpu_bus_pkg::cpu_bus_t    cpu_bus,
    output cpu_bus_pkg::data_word_t       cpu_mem_in,
    output logic [7:0]                    hs_data_out,
    output logic                          hs_data_ready
);

    logic                    cpu_resp;
    logic                    hs_resp;
    cpu_bus_pkg::data_word_t cpu_word;

    assign cpu_resp = resp_valid & ~resp.is_hs;
    assign hs_resp  = resp_valid & resp.is_hs;

    // ==================================================================
    // Data latches
    // ==================================================================
    always_ff @(posedge CLK_32M) begin
        if (cpu_resp) begin
            cpu_word <= resp.data;
        end
        if (hs_resp) begin
            hs_data_out <= resp.odd ? resp.data[15:8] : resp.data[7:0];
        end
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            hs_data_ready <= 1'b0;
        end else begin
            hs_data_ready <= hs_resp;
        end
    end

    // Odd CPU address reads the high byte in the low lane
    assign cpu_mem_in = cpu_bus.addr[0] ? {8'h00, cpu_word[15:8]} : cpu_word;

    a_hs_ready_pulse: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        hs_data_ready |=> !hs_data_ready);

endmodule

`default_nettype wire

/* src/m72_mem_bridge.sv */
// Top level of the CPU and high-score to SDRAM bridge
`default_nettype none

module m72_mem_bridge (
    input  wire                           CLK_32M,
    input  wire                           reset_n,
    input  wire cpu_bus_pkg::cpu_bus_t    cpu_bus,
    input  wire cpu_bus_pkg::hs_bus_t     hs_bus,
    input  wire cpu_bus_pkg::data_word_t  sdr_dout,
    input  wire                           sdr_rdy,
    output logic                          cpu_ce,
    output cpu_bus_pkg::data_word_t       cpu_mem_in,
    output logic [7:0]                    hs_data_out,
    output logic                          hs_data_ready,
    output sdram_pkg::sdr_addr_t          sdr_addr,
    output cpu_bus_pkg::data_word_t       sdr_din,
    output cpu_bus_pkg::byte_sel_t        sdr_wr_sel,
    output logic                          sdr_req,
    output logic                          sdr_busy
);

    sdram_pkg::mem_req_t  req;
    logic                 req_valid;
    sdram_pkg::mem_resp_t resp;
    logic                 resp_valid;

    request_capture u_capture (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .cpu_bus   (cpu_bus),
        .hs_bus    (hs_bus),
        .req       (req),
        .req_valid (req_valid)
    );

    request_slot u_slot (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .req        (req),
        .req_valid  (req_valid),
        .sdr_dout   (sdr_dout),
        .sdr_rdy    (sdr_rdy),
        .sdr_addr   (sdr_addr),
        .sdr_din    (sdr_din),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_busy   (sdr_busy),
        .resp       (resp),
        .resp_valid (resp_valid),
        .cpu_ce     (cpu_ce)
    );

    response_steer u_steer (
        .CLK_32M       (CLK_32M),
        .reset_n       (reset_n),
        .resp          (resp),
        .resp_valid    (resp_valid),
        .cpu_bus       (cpu_bus),
        .cpu_mem_in    (cpu_mem_in),
        .hs_data_out   (hs_data_out),
        .hs_data_ready (hs_data_ready)
    );

endmodule

`default_nettype wire

/* sim/sdram_model.sv */
// Behavioral SDRAM responder with fixed latency and address-derived read data
`default_nettype none

module sdram_model (
    input  wire                          CLK_32M,
    input  wire                          reset_n,
    input  wire sdram_pkg::sdr_addr_t    sdr_addr,
    input  wire cpu_bus_pkg::data_word_t sdr_din,
    input  wire cpu_bus_pkg::byte_sel_t  sdr_wr_sel,
    input  wire                          sdr_req,
    output cpu_bus_pkg::data_word_t      sdr_dout,
    output logic                         sdr_rdy,
    output sdram_pkg::sdr_addr_t         last_addr,
    output cpu_bus_pkg::data_word_t      last_din,
    output cpu_bus_pkg::byte_sel_t       last_wr_sel,
    output logic [31:0]                  req_count
);

    logic [1:0] wait_cnt;   // Cycles left before sdr_rdy

    // sdr_rdy comes 3 cycles after sdr_req
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            wait_cnt    <= 2'd0;
            sdr_rdy     <= 1'b0;
            sdr_dout    <= '0;
            last_addr   <= '0;
            last_din    <= '0;
            last_wr_sel <= '0;
            req_count   <= '0;
        end else begin
            sdr_rdy <= 1'b0;
            if (sdr_req) begin
                wait_cnt    <= 2'd2;
                last_addr   <= sdr_addr;
                last_din    <= sdr_din;
                last_wr_sel <= sdr_wr_sel;
                req_count   <= req_count + 1'b1;
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (wait_cnt == 2'd1) begin
                sdr_rdy  <= 1'b1;
                sdr_dout <= sdr_addr[15:0] ^ 16'h5A5A;   // Data rule
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_m72_mem_bridge.sv */
// Table-driven testbench for the CPU and high-score SDRAM bridge
`default_nettype none
`include "m72_mem_defines.svh"

module tb_m72_mem_bridge;

    localparam int NUM_ROWS    = 13;
    localparam int CYCLE_LIMIT = NUM_ROWS * 30 + 50;

    typedef struct packed {
        logic                    is_hs;
        logic                    wr;
        cpu_bus_pkg::cpu_addr_t  addr;
        cpu_bus_pkg::data_word_t wdata;
        cpu_bus_pkg::byte_sel_t  sel;
        sdram_pkg::sdr_addr_t    exp_addr;
        cpu_bus_pkg::data_word_t exp_din;
        cpu_bus_pkg::byte_sel_t  exp_wr_sel;
        logic                    exp_req;
        cpu_bus_pkg::data_word_t exp_rd;
    } row_t;

    logic                    CLK_32M;
    logic                    reset_n;
    cpu_bus_pkg::cpu_bus_t   cpu_bus;
    cpu_bus_pkg::hs_bus_t    hs_bus;
    cpu_bus_pkg::data_word_t sdr_dout;
    logic                    sdr_rdy;
    logic                    cpu_ce;
    cpu_bus_pkg::data_word_t cpu_mem_in;
    logic [7:0]              hs_data_out;
    logic                    hs_data_ready;
    sdram_pkg::sdr_addr_t    sdr_addr;
    cpu_bus_pkg::data_word_t sdr_din;
    cpu_bus_pkg::byte_sel_t  sdr_wr_sel;
    logic                    sdr_req;
    logic                    sdr_busy;
    sdram_pkg::sdr_addr_t    last_addr;
    cpu_bus_pkg::data_word_t last_din;
    cpu_bus_pkg::byte_sel_t  last_wr_sel;
    logic [31:0]             req_count;
    row_t                    rows [NUM_ROWS];
    int                      err_cnt;
    int                      check_cnt;
    int                      cycle_cnt;

    m72_mem_bridge uut (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .cpu_bus(cpu_bus), .hs_bus(hs_bus),
        .sdr_dout(sdr_dout), .sdr_rdy(sdr_rdy), .cpu_ce(cpu_ce), .cpu_mem_in(cpu_mem_in),
        .hs_data_out(hs_data_out), .hs_data_ready(hs_data_ready), .sdr_addr(sdr_addr),
        .sdr_din(sdr_din), .sdr_wr_sel(sdr_wr_sel), .sdr_req(sdr_req), .sdr_busy(sdr_busy)
    );

    sdram_model sdram (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .sdr_addr(sdr_addr), .sdr_din(sdr_din),
        .sdr_wr_sel(sdr_wr_sel), .sdr_req(sdr_req), .sdr_dout(sdr_dout), .sdr_rdy(sdr_rdy),
        .last_addr(last_addr), .last_din(last_din), .last_wr_sel(last_wr_sel),
        .req_count(req_count)
    );

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic row_t make_row(input logic is_hs, input logic wr, input logic [19:0] addr,
                                      input logic [15:0] wdata, input logic [1:0] sel,
                                      input logic [24:0] exp_addr, input logic [15:0] exp_din,
                                      input logic [1:0] exp_wr_sel, input logic exp_req,
                                      input logic [15:0] exp_rd);
        make_row = {is_hs, wr, addr, wdata, sel, exp_addr, exp_din, exp_wr_sel, exp_req, exp_rd};
    endfunction

    // ==================================================================
    // Stimulus table
    // ==================================================================
    task automatic load_table();
        rows[0]  = make_row(0, 0, 'h01234, 'h0000, 2'b11, 'h0001234, 'h0000, 2'b00, 1, 'h486E);
        rows[1]  = make_row(0, 0, 'h3ABCD, 'h0000, 2'b11, 'h003ABCC, 'h0000, 2'b00, 1, 'h00F1);
        rows[2]  = make_row(0, 1, 'hA0101, 'h0077, 2'b01, 'h01A0100, 'h7700, 2'b10, 1, 'h0000);
        rows[3]  = make_row(0, 1, 'hA3FFE, 'hBEEF, 2'b11, 'h01A3FFE, 'hBEEF, 2'b11, 1, 'h0000);
        rows[4]  = make_row(0, 1, 'h00010, 'h1111, 2'b11, 'h0000010, 'h0000, 2'b00, 1, 'h0000);
        // Just outside the ROM and RAM windows
        rows[5]  = make_row(0, 0, 'h80000, 'h0000, 2'b11, 'h0000000, 'h0000, 2'b00, 0, 'h0000);
        rows[6]  = make_row(0, 1, 'hA4000, 'h0055, 2'b01, 'h0000000, 'h0000, 2'b00, 0, 'h0000);
        rows[7]  = make_row(0, 0, 'hA2002, 'h0000, 2'b11, 'h01A2002, 'h0000, 2'b00, 1, 'h7A58);
        rows[8]  = make_row(1, 1, 'h00010, 'h003C, 2'b00, 'h0100010, 'h3C3C, 2'b01, 1, 'h0000);
        rows[9]  = make_row(1, 1, 'h1FFFF, 'h00A5, 2'b00, 'h011FFFF, 'hA5A5, 2'b10, 1, 'h0000);
        rows[10] = make_row(1, 0, 'h00123, 'h0000, 2'b00, 'h0100123, 'h0000, 2'b00, 1, 'h005B);
        rows[11] = make_row(1, 0, 'h04444, 'h0000, 2'b00, 'h0104444, 'h0000, 2'b00, 1, 'h001E);
        rows[12] = make_row(0, 0, 'h7FFFF, 'h0000, 2'b11, 'h007FFFE, 'h0000, 2'b00, 1, 'h00A5);
    endtask

    task automatic check_idle_ce();
        int i;
        int last_ce;
        int pulses;
        last_ce = -1;
        pulses  = 0;
        @(negedge CLK_32M);
        compare_value(sdr_req, 1'b0, "sdr_req after reset");
        compare_value(sdr_busy, 1'b0, "sdr_busy after reset");
        compare_value(hs_data_ready, 1'b0, "hs_data_ready after reset");
        for (i = 0; i < 16; i++) begin
            @(negedge CLK_32M);
            if (cpu_ce) begin
                if (last_ce >= 0) compare_value(i - last_ce, 4, "cpu_ce spacing");
                last_ce = i;
                pulses++;
            end
        end
        compare_value(pulses, 4, "cpu_ce pulses in 16 idle cycles");
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] start_cnt;
        int          n;
        int          rdy_at;
        int          ready_cnt;
        logic        done;
        logic [15:0] cpu_val;
        logic [7:0]  hs_val;
        r         = rows[idx];
        start_cnt = req_count;
        n         = 0;
        rdy_at    = -1;
        ready_cnt = 0;
        done      = 1'b0;
        cpu_val   = '0;
        hs_val    = '0;
        @(posedge CLK_32M);
        #1;
        if (r.is_hs) begin
            hs_bus.addr = r.addr[`M72_HS_AW-1:0];
            hs_bus.din  = r.wdata[7:0];
            hs_bus.rd   = !r.wr;
            hs_bus.wr   = r.wr;
        end else begin
            cpu_bus.addr = r.addr;
            cpu_bus.dout = r.wdata;
            cpu_bus.sel  = r.sel;
            cpu_bus.rd   = !r.wr;
            cpu_bus.wr   = r.wr;
        end
        @(posedge CLK_32M);
        #1;
        cpu_bus.rd = 1'b0;   // Address stays so cpu_mem_in keeps following it
        cpu_bus.wr = 1'b0;
        hs_bus.rd  = 1'b0;
        hs_bus.wr  = 1'b0;
        while (!done && n < 20) begin
            @(negedge CLK_32M);
            if (sdr_rdy) rdy_at = n;
            if (hs_data_ready) ready_cnt++;
            if (rdy_at >= 0 && n == rdy_at + 2) begin
                cpu_val = cpu_mem_in;
                hs_val  = hs_data_out;
            end
            if (r.exp_req) done = (rdy_at >= 0 && n == rdy_at + 3);
            else           done = (n >= 5);
            n++;
        end
        if (r.exp_req && rdy_at < 0) begin
            $display("Row %0d got no SDRAM response within 20 cycles", idx);
            err_cnt++;
        end
        compare_value(req_count - start_cnt, r.exp_req, $sformatf("row %0d sdr_req count", idx));
        if (r.exp_req && rdy_at >= 0) begin
            compare_value(last_addr, r.exp_addr, $sformatf("row %0d sdr_addr", idx));
            compare_value(last_wr_sel, r.exp_wr_sel, $sformatf("row %0d sdr_wr_sel", idx));
            if (r.exp_wr_sel != 2'b00)
                compare_value(last_din, r.exp_din, $sformatf("row %0d sdr_din", idx));
            compare_value(sdr_busy, 1'b0, $sformatf("row %0d sdr_busy at end", idx));
            if (!r.is_hs) begin
                compare_value(ready_cnt, 0, $sformatf("row %0d hs_data_ready pulses", idx));
                if (!r.wr) compare_value(cpu_val, r.exp_rd, $sformatf("row %0d cpu_mem_in", idx));
            end else if (!r.wr) begin
                compare_value(hs_val, r.exp_rd[7:0], $sformatf("row %0d hs_data_out", idx));
                compare_value(ready_cnt, 1, $sformatf("row %0d hs_data_ready pulses", idx));
            end
        end
    endtask

    // ==================================================================
    // Clock, monitor, timeout and main sequence
    // ==================================================================
    initial begin
        CLK_32M = 1'b0;
        forever #4 CLK_32M = ~CLK_32M;
    end

    always @(negedge CLK_32M) begin
        if (reset_n && sdr_busy) compare_value(cpu_ce, 1'b0, "cpu_ce while sdr_busy");
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge CLK_32M);
            cycle_cnt++;
        end
        $display("Run stopped at the limit of %0d cycles before the table was done", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        int idx;
        reset_n   = 1'b0;
        cpu_bus   = '0;
        hs_bus    = '0;
        err_cnt   = 0;
        check_cnt = 0;
        load_table();
        repeat (5) @(posedge CLK_32M);
        #1;
        reset_n = 1'b1;
        check_idle_ce();
        for (idx = 0; idx < NUM_ROWS; idx++) begin
            run_row(idx);
        end
        $display("Checks: %0d  Errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/cpu_bus_pkg.sv
src/sdram_pkg.sv
src/request_capture.sv
src/request_slot.sv
src/response_steer.sv
src/m72_mem_bridge.sv
sim/sdram_model.sv
sim/tb_m72_mem_bridge.sv
